// File: peripheral_subsystem.f
rtl/periph_pkg.sv
rtl/obi_to_reg.sv
rtl/reg_demux.sv
rtl/soc_ctrl.sv
rtl/uart_regs.sv
rtl/uart_serial.sv
rtl/peripheral_subsystem.sv
test/tb_peripheral_subsystem.sv

// File: rtl/obi_to_reg.sv
/* OBI slave to register bus bridge. The master must hold the request until gnt;
   rvalid with rdata and err follows gnt by one cycle, for reads and writes alike. */
`timescale 1ns/1ps
`default_nettype none

module obi_to_reg (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::obi_req_t obi_req_i,
  input  periph_pkg::reg_rsp_t reg_rsp_i,
  output periph_pkg::obi_rsp_t obi_rsp_o,
  output periph_pkg::reg_req_t reg_req_o
);

  logic        gnt;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;
  assign reg_req_o.wstrb = obi_req_i.be;

  // Grant in the cycle the target completes
  assign gnt = obi_req_i.req && reg_rsp_i.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (gnt) begin
        err_q <= reg_rsp_i.error;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= reg_rsp_i.rdata;
    end
  end

  assign obi_rsp_o.gnt    = gnt;
  assign obi_rsp_o.rvalid = rvalid_q;
  assign obi_rsp_o.err    = err_q;
  assign obi_rsp_o.rdata  = rdata_q;

  // Master side of the handshake
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    obi_req_i.req && !gnt |=> obi_req_i.req && $stable(obi_req_i.addr) &&
                              $stable(obi_req_i.we) && $stable(obi_req_i.wdata))
    else $error("OBI request changed before gnt");

endmodule

`default_nettype wire

// File: rtl/periph_pkg.sv
/* Bus structs, address map and register offsets of the peripheral subsystem.
   Address bits [15:12] select a target, and the low 12 bits give the register offset. */
`default_nettype none

package periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Low bits of the UART STATUS register
  typedef struct packed {
    logic tx_busy;
    logic rx_valid;
    logic rx_overflow;
    logic rx_frame_err;
  } uart_status_t;

  localparam int unsigned n_targets    = 3;
  localparam int unsigned idx_soc_ctrl = 0;
  localparam int unsigned idx_uart     = 1;
  localparam int unsigned idx_ext      = 2;

  localparam logic [3:0] region_soc_ctrl = 4'h0;
  localparam logic [3:0] region_uart     = 4'h1;
  localparam logic [3:0] region_ext      = 4'h2;

  localparam logic [11:0] soc_exit_valid_off = 12'h000;
  localparam logic [11:0] soc_exit_value_off = 12'h004;
  localparam logic [11:0] soc_scratch_off    = 12'h008;

  localparam logic [11:0] uart_ctrl_off   = 12'h000;
  localparam logic [11:0] uart_status_off = 12'h004;
  localparam logic [11:0] uart_txdata_off = 12'h008;
  localparam logic [11:0] uart_rxdata_off = 12'h00C;

  function automatic logic [3:0] region_bits(input logic [31:0] addr);
    return addr[15:12];
  endfunction

  // Byte-lane merge of a register write
  function automatic logic [31:0] strobe_merge(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// File: rtl/peripheral_subsystem.sv
/* Peripheral subsystem: one OBI slave port onto SoC control, an 8N1 UART and an
   external register port. Unmapped regions return an OBI error. */
`timescale 1ns/1ps
`default_nettype none

module peripheral_subsystem #(
  parameter int unsigned clks_per_bit = 868
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  input  periph_pkg::obi_req_t obi_req_i,
  output periph_pkg::obi_rsp_t obi_rsp_o,

  // External peripheral
  output periph_pkg::reg_req_t ext_req_o,
  input  periph_pkg::reg_rsp_t ext_rsp_i,

  output logic                 exit_valid_o,
  output logic [31:0]          exit_value_o,

  // UART
  input  logic                 uart_rx_i,
  output logic                 uart_tx_o,
  output logic                 uart_intr_rx_valid_o,
  output logic                 uart_intr_tx_empty_o,
  output logic                 uart_intr_rx_overflow_o,
  output logic                 uart_intr_rx_frame_err_o
);

  periph_pkg::reg_req_t                             periph_req;
  periph_pkg::reg_rsp_t                             periph_rsp;
  periph_pkg::reg_req_t [periph_pkg::n_targets-1:0] slv_req;
  periph_pkg::reg_rsp_t [periph_pkg::n_targets-1:0] slv_rsp;

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       rx_en;
  logic       rx_done;
  logic [7:0] rx_byte;
  logic       rx_frame_err;

  assign ext_req_o                     = slv_req[periph_pkg::idx_ext];
  assign slv_rsp[periph_pkg::idx_ext]  = ext_rsp_i;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i,
    .reg_rsp_i(periph_rsp),
    .obi_rsp_o,
    .reg_req_o(periph_req)
  );

  reg_demux reg_demux_i (
    .clk_i,
    .arst_n_i,
    .in_req_i (periph_req),
    .out_rsp_i(slv_rsp),
    .in_rsp_o (periph_rsp),
    .out_req_o(slv_req)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i(slv_req[periph_pkg::idx_soc_ctrl]),
    .reg_rsp_o(slv_rsp[periph_pkg::idx_soc_ctrl]),
    .exit_valid_o,
    .exit_value_o
  );

  uart_regs uart_regs_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i          (slv_req[periph_pkg::idx_uart]),
    .tx_busy_i          (tx_busy),
    .rx_done_i          (rx_done),
    .rx_byte_i          (rx_byte),
    .rx_frame_err_i     (rx_frame_err),
    .reg_rsp_o          (slv_rsp[periph_pkg::idx_uart]),
    .tx_start_o         (tx_start),
    .tx_byte_o          (tx_byte),
    .rx_en_o            (rx_en),
    .intr_rx_valid_o    (uart_intr_rx_valid_o),
    .intr_tx_empty_o    (uart_intr_tx_empty_o),
    .intr_rx_overflow_o (uart_intr_rx_overflow_o),
    .intr_rx_frame_err_o(uart_intr_rx_frame_err_o)
  );

  uart_serial #(
    .clks_per_bit(clks_per_bit)
  ) uart_serial_i (
    .clk_i,
    .arst_n_i,
    .tx_start_i    (tx_start),
    .tx_byte_i     (tx_byte),
    .rx_en_i       (rx_en),
    .uart_rx_i,
    .uart_tx_o,
    .tx_busy_o     (tx_busy),
    .rx_done_o     (rx_done),
    .rx_byte_o     (rx_byte),
    .rx_frame_err_o(rx_frame_err)
  );

endmodule

`default_nettype wire

// File: rtl/reg_demux.sv
/* Register bus demux over address bits [15:12]. Unmapped regions answer ready
   with error and zero data at once; no target sees their valid. */
`timescale 1ns/1ps
`default_nettype none

module reg_demux (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  periph_pkg::reg_req_t                             in_req_i,
  input  periph_pkg::reg_rsp_t [periph_pkg::n_targets-1:0] out_rsp_i,
  output periph_pkg::reg_rsp_t                             in_rsp_o,
  output periph_pkg::reg_req_t [periph_pkg::n_targets-1:0] out_req_o
);

  localparam int unsigned sel_w = $clog2(periph_pkg::n_targets);

  logic                           sel_hit;
  logic [sel_w-1:0]               sel_idx;
  logic [periph_pkg::n_targets-1:0] out_valid;

  // Region decode
  always_comb begin
    sel_hit = 1'b1;
    sel_idx = '0;
    case (periph_pkg::region_bits(in_req_i.addr))
      periph_pkg::region_soc_ctrl: sel_idx = sel_w'(periph_pkg::idx_soc_ctrl);
      periph_pkg::region_uart:     sel_idx = sel_w'(periph_pkg::idx_uart);
      periph_pkg::region_ext:      sel_idx = sel_w'(periph_pkg::idx_ext);
      default:                     sel_hit = 1'b0;
    endcase
  end

  always_comb begin
    for (int unsigned i = 0; i < periph_pkg::n_targets; i++) begin
      out_valid[i]       = in_req_i.valid && sel_hit && (sel_idx == sel_w'(i));
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = out_valid[i];
    end
  end

  always_comb begin
    if (sel_hit) begin
      in_rsp_o = out_rsp_i[sel_idx];
    end else begin
      in_rsp_o.ready = 1'b1;
      in_rsp_o.error = 1'b1;
      in_rsp_o.rdata = '0;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(out_valid))
    else $error("More than one register target selected");

endmodule

`default_nettype wire

// File: rtl/soc_ctrl.sv
/* SoC control registers: exit valid, exit value and scratch, all byte-strobed.
   Always ready; an unknown offset reads zero and returns an error. */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 exit_valid_o,
  output logic [31:0]          exit_value_o
);

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;
  logic [11:0] offset;
  logic        wr_en;

  assign offset = reg_req_i.addr[11:0];
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (offset)
        periph_pkg::soc_exit_valid_off: begin
          if (reg_req_i.wstrb[0]) begin
            exit_valid_q <= reg_req_i.wdata[0];
          end
        end
        periph_pkg::soc_exit_value_off: begin
          exit_value_q <= periph_pkg::strobe_merge(exit_value_q, reg_req_i.wdata,
                                                   reg_req_i.wstrb);
        end
        periph_pkg::soc_scratch_off: begin
          scratch_q <= periph_pkg::strobe_merge(scratch_q, reg_req_i.wdata, reg_req_i.wstrb);
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::soc_exit_valid_off: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      periph_pkg::soc_exit_value_off: reg_rsp_o.rdata = exit_value_q;
      periph_pkg::soc_scratch_off:    reg_rsp_o.rdata = scratch_q;
      default: begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.error = 1'b1;
      end
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// File: rtl/uart_regs.sv
/* UART register block beside the serial engine. A TXDATA write while the transmitter
   is busy stalls ready; a frame with a bad stop bit only sets the frame-error flag. */
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  input  logic                 tx_busy_i,
  input  logic                 rx_done_i,
  input  logic [7:0]           rx_byte_i,
  input  logic                 rx_frame_err_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 tx_start_o,
  output logic [7:0]           tx_byte_o,
  output logic                 rx_en_o,
  output logic                 intr_rx_valid_o,
  output logic                 intr_tx_empty_o,
  output logic                 intr_rx_overflow_o,
  output logic                 intr_rx_frame_err_o
);

  logic [11:0]              offset;
  logic                     wr_en;
  logic                     txdata_wr;
  logic                     rxdata_rd;
  logic                     status_wr;
  logic                     rx_good;
  logic                     rx_push;
  logic                     tx_en_q;
  logic                     rx_en_q;
  logic                     rx_valid_q;
  logic                     rx_overflow_q;
  logic                     rx_frame_err_q;
  logic [7:0]               rx_data_q;
  periph_pkg::uart_status_t status;
  periph_pkg::uart_status_t status_clr;

  assign offset     = reg_req_i.addr[11:0];
  assign wr_en      = reg_req_i.valid && reg_req_i.write;
  assign txdata_wr  = wr_en && (offset == periph_pkg::uart_txdata_off);
  assign status_wr  = wr_en && (offset == periph_pkg::uart_status_off) && reg_req_i.wstrb[0];
  assign rxdata_rd  = reg_req_i.valid && !reg_req_i.write &&
                      (offset == periph_pkg::uart_rxdata_off);
  assign status_clr = periph_pkg::uart_status_t'(reg_req_i.wdata[3:0]);

  // Frame starts the cycle after the write completes
  assign tx_start_o = txdata_wr && tx_en_q && !tx_busy_i;
  assign tx_byte_o  = reg_req_i.wdata[7:0];

  // A byte read out in the same cycle makes room for the new one
  assign rx_good = rx_done_i && !rx_frame_err_i;
  assign rx_push = rx_good && (!rx_valid_q || rxdata_rd);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_en_q        <= 1'b0;
      rx_en_q        <= 1'b0;
      rx_valid_q     <= 1'b0;
      rx_overflow_q  <= 1'b0;
      rx_frame_err_q <= 1'b0;
      rx_data_q      <= '0;
    end else begin
      if (wr_en && (offset == periph_pkg::uart_ctrl_off) && reg_req_i.wstrb[0]) begin
        tx_en_q <= reg_req_i.wdata[0];
        rx_en_q <= reg_req_i.wdata[1];
      end
      if (rx_push) begin
        rx_valid_q <= 1'b1;
        rx_data_q  <= rx_byte_i;
      end else if (rxdata_rd) begin
        rx_valid_q <= 1'b0;
      end
      // Setting wins over a write-1 clear
      if (rx_good && !rx_push) begin
        rx_overflow_q <= 1'b1;
      end else if (status_wr && status_clr.rx_overflow) begin
        rx_overflow_q <= 1'b0;
      end
      if (rx_done_i && rx_frame_err_i) begin
        rx_frame_err_q <= 1'b1;
      end else if (status_wr && status_clr.rx_frame_err) begin
        rx_frame_err_q <= 1'b0;
      end
    end
  end

  assign status.tx_busy      = tx_busy_i;
  assign status.rx_valid     = rx_valid_q;
  assign status.rx_overflow  = rx_overflow_q;
  assign status.rx_frame_err = rx_frame_err_q;

  always_comb begin
    reg_rsp_o.ready = !(txdata_wr && tx_en_q && tx_busy_i);
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::uart_ctrl_off:   reg_rsp_o.rdata = {30'b0, rx_en_q, tx_en_q};
      periph_pkg::uart_status_off: reg_rsp_o.rdata = {28'b0, status};
      periph_pkg::uart_txdata_off: reg_rsp_o.rdata = '0;
      periph_pkg::uart_rxdata_off: reg_rsp_o.rdata = {24'b0, rx_data_q};
      default: begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.error = 1'b1;
      end
    endcase
  end

  assign rx_en_o             = rx_en_q;
  assign intr_rx_valid_o     = rx_valid_q;
  assign intr_tx_empty_o     = tx_en_q && !tx_busy_i;
  assign intr_rx_overflow_o  = rx_overflow_q;
  assign intr_rx_frame_err_o = rx_frame_err_q;

endmodule

`default_nettype wire

// File: rtl/uart_serial.sv
/* 8N1 transmit and receive engines, clks_per_bit cycles per bit (at least 4).
   The receiver samples mid-bit after a two-flop synchroniser and only starts while enabled. */
`timescale 1ns/1ps
`default_nettype none

module uart_serial #(
  parameter int unsigned clks_per_bit = 868
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       tx_start_i,
  input  logic [7:0] tx_byte_i,
  input  logic       rx_en_i,
  input  logic       uart_rx_i,
  output logic       uart_tx_o,
  output logic       tx_busy_o,
  output logic       rx_done_o,
  output logic [7:0] rx_byte_o,
  output logic       rx_frame_err_o
);

  localparam int unsigned      cnt_w    = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] cnt_mid  = cnt_w'(clks_per_bit / 2);

  logic             tx_busy_q;
  logic [cnt_w-1:0] tx_cnt_q;
  logic [3:0]       tx_idx_q;
  logic [9:0]       tx_shift_q;

  logic             rx_meta_q;
  logic             rx_sync_q;
  logic             rx_prev_q;
  logic             rx_active_q;
  logic [cnt_w-1:0] rx_cnt_q;
  logic [3:0]       rx_idx_q;
  logic [7:0]       rx_shift_q;
  logic             rx_done_q;
  logic             rx_frame_err_q;

  // Stop, data LSB first, start; ones shift in behind
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy_q  <= 1'b0;
      tx_cnt_q   <= '0;
      tx_idx_q   <= '0;
      tx_shift_q <= '1;
    end else if (tx_start_i) begin
      tx_busy_q  <= 1'b1;
      tx_cnt_q   <= '0;
      tx_idx_q   <= '0;
      tx_shift_q <= {1'b1, tx_byte_i, 1'b0};
    end else if (tx_busy_q) begin
      if (tx_cnt_q == cnt_last) begin
        tx_cnt_q   <= '0;
        tx_shift_q <= {1'b1, tx_shift_q[9:1]};
        if (tx_idx_q == 4'd9) begin
          tx_busy_q <= 1'b0;
        end else begin
          tx_idx_q <= tx_idx_q + 4'd1;
        end
      end else begin
        tx_cnt_q <= tx_cnt_q + 1'b1;
      end
    end
  end

  assign uart_tx_o = tx_shift_q[0];
  assign tx_busy_o = tx_busy_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= uart_rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_active_q    <= 1'b0;
      rx_cnt_q       <= '0;
      rx_idx_q       <= '0;
      rx_shift_q     <= '0;
      rx_done_q      <= 1'b0;
      rx_frame_err_q <= 1'b0;
    end else begin
      rx_done_q <= 1'b0;
      if (!rx_active_q) begin
        if (rx_en_i && rx_prev_q && !rx_sync_q) begin
          rx_active_q <= 1'b1;
          rx_cnt_q    <= '0;
          rx_idx_q    <= '0;
        end
      end else begin
        if (rx_cnt_q == cnt_last) begin
          rx_cnt_q <= '0;
          rx_idx_q <= rx_idx_q + 4'd1;
        end else begin
          rx_cnt_q <= rx_cnt_q + 1'b1;
        end
        if (rx_cnt_q == cnt_mid) begin
          if (rx_idx_q == 4'd0) begin
            // Start bit gone by mid-bit is a glitch
            if (rx_sync_q) begin
              rx_active_q <= 1'b0;
            end
          end else if (rx_idx_q == 4'd9) begin
            rx_active_q    <= 1'b0;
            rx_done_q      <= 1'b1;
            rx_frame_err_q <= !rx_sync_q;
          end else begin
            rx_shift_q <= {rx_sync_q, rx_shift_q[7:1]};
          end
        end
      end
    end
  end

  assign rx_done_o      = rx_done_q;
  assign rx_byte_o      = rx_shift_q;
  assign rx_frame_err_o = rx_frame_err_q;

  // Register block must hold off while a frame is on the line
  assert property (@(posedge clk_i) disable iff (!arst_n_i) tx_start_i |-> !tx_busy_q)
    else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
# Exit status is 0 only when the log has no failure line.

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_peripheral_subsystem \
  -f peripheral_subsystem.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
  || grep -q "TESTS PASSED" sim.log \
  || { echo "Simulation ended without a result"; exit 1; }

// File: test/tb_peripheral_subsystem.sv
/* Testbench for the peripheral subsystem with clks_per_bit of 8.
   Models the external register target and both UART line ends. */
`timescale 1ns/1ps
`default_nettype none

module tb_peripheral_subsystem;

  localparam int unsigned clks_per_bit = 8;
  localparam int unsigned max_cycles   = 20000;
  localparam logic [31:0] soc_base     = 32'h0000_0000;
  localparam logic [31:0] uart_base    = 32'h0000_1000;
  localparam logic [31:0] ext_base     = 32'h0000_2000;
  localparam int          ev_rx_ok     = 0;
  localparam int          ev_rx_bad    = 1;
  localparam int          ev_rx_read   = 2;
  localparam int          ev_clear     = 3;

  logic                     clk;
  logic                     arst_n;
  logic                     uart_rx;
  logic                     uart_tx;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic                     intr_rx_valid;
  logic                     intr_tx_empty;
  logic                     intr_rx_overflow;
  logic                     intr_rx_frame_err;
  periph_pkg::obi_req_t     obi_req;
  periph_pkg::obi_rsp_t     obi_rsp;
  periph_pkg::reg_req_t     ext_req;
  periph_pkg::reg_rsp_t     ext_rsp;
  periph_pkg::reg_req_t     ext_last;
  periph_pkg::uart_status_t exp_status;
  logic [15:0]              lfsr_state;
  logic [31:0]              ext_mem [16];
  logic [31:0]              exp_mem [16];
  logic [31:0]              ext_pick;
  logic                     ext_busy;
  int unsigned              ext_wait;
  int unsigned              frames_seen;
  int unsigned              cycle_count = 0;

  peripheral_subsystem #(
    .clks_per_bit(clks_per_bit)
  ) uut (
    .clk_i                   (clk),
    .arst_n_i                (arst_n),
    .obi_req_i               (obi_req),
    .obi_rsp_o               (obi_rsp),
    .ext_req_o               (ext_req),
    .ext_rsp_i               (ext_rsp),
    .exit_valid_o            (exit_valid),
    .exit_value_o            (exit_value),
    .uart_rx_i               (uart_rx),
    .uart_tx_o               (uart_tx),
    .uart_intr_rx_valid_o    (intr_rx_valid),
    .uart_intr_tx_empty_o    (intr_tx_empty),
    .uart_intr_rx_overflow_o (intr_rx_overflow),
    .uart_intr_rx_frame_err_o(intr_rx_frame_err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      abort($sformatf("Timeout: run did not finish within %0d cycles", max_cycles));
    end
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int unsigned n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Expected word after a byte-strobed write
  function automatic logic [31:0] merge_ref(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] be);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  function automatic periph_pkg::uart_status_t status_after(input periph_pkg::uart_status_t s,
                                                            input int ev, input logic [3:0] clr);
    periph_pkg::uart_status_t n;
    n = s;
    case (ev)
      ev_rx_ok: begin
        if (s.rx_valid) n.rx_overflow = 1'b1;
        else n.rx_valid = 1'b1;
      end
      ev_rx_bad:  n.rx_frame_err = 1'b1;
      ev_rx_read: n.rx_valid = 1'b0;
      default: begin
        if (clr[1]) n.rx_overflow = 1'b0;
        if (clr[0]) n.rx_frame_err = 1'b0;
      end
    endcase
    return n;
  endfunction

  function automatic periph_pkg::obi_rsp_t rsp_of(input logic err, input logic [31:0] rdata);
    periph_pkg::obi_rsp_t r;
    r.gnt    = 1'b0;
    r.rvalid = 1'b1;
    r.err    = err;
    r.rdata  = rdata;
    return r;
  endfunction

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort($sformatf("[ERROR] %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp));
    end
  endtask

  task automatic compare_rsp(input periph_pkg::obi_rsp_t got, input periph_pkg::obi_rsp_t exp,
                             input string what);
    if (got !== exp) begin
      abort($sformatf("[ERROR] %0t: %s got %b %b %b 0x%08h, expected %b %b %b 0x%08h",
                      $time, what, got.gnt, got.rvalid, got.err, got.rdata,
                      exp.gnt, exp.rvalid, exp.err, exp.rdata));
    end
  endtask

  task automatic compare_status(input periph_pkg::uart_status_t got,
                                input periph_pkg::uart_status_t exp, input string what);
    if (got !== exp) begin
      abort($sformatf("[ERROR] %0t: %s status got %b expected %b", $time, what, got, exp));
    end
  endtask

  // Holds the request until gnt, then takes the response in the rvalid cycle
  task automatic obi_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output periph_pkg::obi_rsp_t rsp);
    @(posedge clk);
    #1;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    @(negedge clk);
    while (!obi_rsp.gnt) @(negedge clk);
    @(posedge clk);
    #1;
    obi_req = '0;
    @(negedge clk);
    if (!obi_rsp.rvalid) abort("OBI rvalid did not follow gnt by one cycle");
    rsp = obi_rsp;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    periph_pkg::obi_rsp_t rsp;
    obi_access(1'b1, addr, wdata, be, rsp);
    // Read data of a write response is undefined
    compare_rsp(rsp, rsp_of(1'b0, rsp.rdata), $sformatf("write 0x%08h", addr));
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] rdata);
    periph_pkg::obi_rsp_t rsp;
    obi_access(1'b0, addr, 32'h0, 4'h0, rsp);
    compare_rsp(rsp, rsp_of(1'b0, rsp.rdata), $sformatf("read 0x%08h", addr));
    rdata = rsp.rdata;
  endtask

  // External target with a random stall of 0 to 3 cycles
  always @(posedge clk) begin
    if (ext_rsp.ready && ext_req.valid) begin
      ext_last = ext_req;
      if (ext_req.write) begin
        for (int b = 0; b < 4; b++) begin
          if (ext_req.wstrb[b]) ext_mem[ext_req.addr[5:2]][8*b +: 8] = ext_req.wdata[8*b +: 8];
        end
      end
      #1;
      ext_rsp.ready = 1'b0;
      ext_busy      = 1'b0;
    end else begin
      if (ext_req.valid && !ext_busy) begin
        rand_bits(2, ext_pick);
        ext_wait = ext_pick;
        ext_busy = 1'b1;
      end
      if (ext_busy) begin
        if (ext_wait == 0) begin
          #1;
          ext_rsp.ready = 1'b1;
          ext_rsp.rdata = ext_mem[ext_req.addr[5:2]];
        end else begin
          ext_wait--;
        end
      end
    end
  end

  task automatic send_frame(input logic [7:0] data, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      uart_rx = bits[i];
      repeat (clks_per_bit - 1) @(posedge clk);
    end
    @(posedge clk);
    #1;
    uart_rx = 1'b1;
  endtask

  // Samples each bit near its middle
  task automatic capture_frame(input logic [7:0] exp_byte);
    logic [7:0] data;
    @(negedge uart_tx);
    repeat (clks_per_bit / 2) @(negedge clk);
    compare_word(32'(uart_tx), 32'h0, "tx start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data[i] = uart_tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    compare_word(32'(data), 32'(exp_byte), "tx frame data");
    compare_word(32'(uart_tx), 32'h1, "tx stop bit");
  endtask

  initial begin
    logic [31:0]          rd;
    logic [31:0]          exp_scratch;
    logic [31:0]          data;
    logic [31:0]          be;
    periph_pkg::obi_rsp_t rsp;
    arst_n      = 1'b0;
    obi_req     = '0;
    ext_rsp     = '0;
    uart_rx     = 1'b1;
    lfsr_state  = 16'd42;
    ext_busy    = 1'b0;
    ext_wait    = 0;
    frames_seen = 0;
    exp_status  = '0;
    exp_scratch = '0;
    for (int i = 0; i < 16; i++) begin
      ext_mem[i] = '0;
      exp_mem[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    compare_word({obi_rsp.gnt, obi_rsp.rvalid, exit_valid, ext_req.valid}, 32'h0, "reset flags");
    compare_word(exit_value, 32'h0, "reset exit value");
    compare_word(32'(uart_tx), 32'h1, "reset tx line");
    compare_word({intr_rx_valid, intr_tx_empty, intr_rx_overflow, intr_rx_frame_err}, 32'h0,
                 "reset interrupts");

    // SoC control
    obi_write(soc_base + 32'h8, 32'hDEAD_BEEF, 4'b1111);
    exp_scratch = merge_ref(exp_scratch, 32'hDEAD_BEEF, 4'b1111);
    obi_write(soc_base + 32'h8, 32'h1122_3344, 4'b0101);
    exp_scratch = merge_ref(exp_scratch, 32'h1122_3344, 4'b0101);
    obi_read(soc_base + 32'h8, rd);
    compare_word(rd, exp_scratch, "scratch after partial write");
    obi_write(soc_base + 32'h8, 32'hAABB_CCDD, 4'b1000);
    exp_scratch = merge_ref(exp_scratch, 32'hAABB_CCDD, 4'b1000);
    obi_read(soc_base + 32'h8, rd);
    compare_word(rd, exp_scratch, "scratch after top byte write");
    obi_write(soc_base + 32'h4, 32'h1234_5678, 4'b1111);
    compare_word(32'(exit_valid), 32'h0, "exit valid before flag write");
    obi_write(soc_base, 32'h1, 4'b0001);
    compare_word(32'(exit_valid), 32'h1, "exit valid");
    compare_word(exit_value, 32'h1234_5678, "exit value");

    // Unmapped regions
    for (int r = 3; r < 16; r++) begin
      obi_access(1'b1, {16'h0, 4'(r), 12'h008}, 32'hFFFF_FFFF, 4'hF, rsp);
      compare_rsp(rsp, rsp_of(1'b1, 32'h0), "unmapped write");
      obi_access(1'b0, {16'h0, 4'(r), 12'h008}, 32'h0, 4'h0, rsp);
      compare_rsp(rsp, rsp_of(1'b1, 32'h0), "unmapped read");
    end
    obi_read(soc_base + 32'h8, rd);
    compare_word(rd, exp_scratch, "scratch after unmapped writes");

    // External port under random stalls
    for (int i = 0; i < 16; i++) begin
      rand_bits(32, data);
      rand_bits(4, be);
      obi_write(ext_base + 32'(4 * i), data, be[3:0]);
      exp_mem[i] = merge_ref(exp_mem[i], data, be[3:0]);
      compare_word(ext_last.addr, ext_base + 32'(4 * i), "ext address");
      compare_word(ext_last.wdata, data, "ext write data");
      compare_word({ext_last.write, ext_last.wstrb}, {27'h0, 1'b1, be[3:0]}, "ext strobes");
    end
    for (int i = 0; i < 16; i++) begin
      obi_read(ext_base + 32'(4 * i), rd);
      compare_word(rd, exp_mem[i], "ext read data");
    end

    // UART transmit, second byte stalls behind the first frame
    obi_write(uart_base, 32'h3, 4'b0001);
    fork
      begin
        obi_write(uart_base + 32'h8, 32'h0000_00A7, 4'b0001);
        obi_write(uart_base + 32'h8, 32'h0000_005C, 4'b0001);
        if (frames_seen < 1) abort("Second TXDATA write completed before the first frame ended");
      end
      begin
        capture_frame(8'hA7);
        frames_seen = 1;
        capture_frame(8'h5C);
        frames_seen = 2;
      end
    join
    repeat (clks_per_bit) @(negedge clk);
    compare_word(32'(intr_tx_empty), 32'h1, "tx empty after frames");
    obi_write(uart_base, 32'h2, 4'b0001);
    obi_write(uart_base + 32'h8, 32'h0000_00FF, 4'b0001);
    repeat (12 * clks_per_bit) begin
      @(negedge clk);
      compare_word(32'(uart_tx), 32'h1, "tx line with tx disabled");
    end
    compare_word(32'(intr_tx_empty), 32'h0, "tx empty with tx disabled");

    // UART receive
    send_frame(8'hA5, 1'b1);
    while (!intr_rx_valid) @(negedge clk);
    exp_status = status_after(exp_status, ev_rx_ok, 4'h0);
    obi_read(uart_base + 32'h4, rd);
    compare_status(periph_pkg::uart_status_t'(rd[3:0]), exp_status, "after one frame");
    obi_read(uart_base + 32'hC, rd);
    compare_word(rd, 32'hA5, "rx data");
    exp_status = status_after(exp_status, ev_rx_read, 4'h0);
    send_frame(8'h3C, 1'b1);
    while (!intr_rx_valid) @(negedge clk);
    exp_status = status_after(exp_status, ev_rx_ok, 4'h0);
    send_frame(8'hC3, 1'b1);
    while (!intr_rx_overflow) @(negedge clk);
    exp_status = status_after(exp_status, ev_rx_ok, 4'h0);
    obi_read(uart_base + 32'h4, rd);
    compare_status(periph_pkg::uart_status_t'(rd[3:0]), exp_status, "after overflow");
    obi_read(uart_base + 32'hC, rd);
    compare_word(rd, 32'h3C, "rx data kept on overflow");
    exp_status = status_after(exp_status, ev_rx_read, 4'h0);
    send_frame(8'h55, 1'b0);
    while (!intr_rx_frame_err) @(negedge clk);
    exp_status = status_after(exp_status, ev_rx_bad, 4'h0);
    obi_read(uart_base + 32'h4, rd);
    compare_status(periph_pkg::uart_status_t'(rd[3:0]), exp_status, "after bad stop bit");
    obi_write(uart_base + 32'h4, 32'h3, 4'b0001);
    exp_status = status_after(exp_status, ev_clear, 4'h3);
    obi_read(uart_base + 32'h4, rd);
    compare_status(periph_pkg::uart_status_t'(rd[3:0]), exp_status, "after write-1 clear");
    compare_word({intr_rx_overflow, intr_rx_frame_err}, 32'h0, "rx error interrupts cleared");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
